// ==== verilog/dcache_pkg.sv ====
////////////////////////////////////////////////////////////
// Data cache shared types
// Bus bundles for the CPU and memory sides, refill and
// way write records, and the controller state encoding
////////////////////////////////////////////////////////////

package dcache_pkg;

  // Basic bus quantities
  typedef logic [31:0] dat_t;
  typedef logic [31:0] adr_t;
  typedef logic [3:0]  sel_t;

  // CPU side request, Wishbone classic slave view
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    adr_t adr;
    dat_t dat;
    sel_t sel;
  } cpu_req_t;

  // Memory side, master to slave
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    adr_t adr;
    dat_t dat;
    sel_t sel;
  } wb_m2s_t;

  // Memory side, slave to master
  typedef struct packed {
    logic ack;
    dat_t dat;
  } wb_s2m_t;

  // One refill word, offset sized for up to eight words per line
  typedef struct packed {
    logic       valid;
    logic [2:0] offs;
    dat_t       dat;
  } refill_word_t;

  // Data store write, way is a one-hot mask
  typedef struct packed {
    logic [1:0] way;
    adr_t       adr;
    dat_t       dat;
    sel_t       sel;
  } way_wr_t;

  // Cache controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    WRITE_THRU,
    TAG_FILL
  } cache_state_e;

endpackage

// ==== verilog/dcache_tag_store.sv ====
////////////////////////////////////////////////////////////
// Data cache tag store
// Tag RAM per way with synchronous read, valid and LRU
// flops, hit compare and victim way
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dcache_tag_store #(
  parameter int SET_W  = 4,
  parameter int WORD_W = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  dcache_pkg::adr_t adr_i,
  input  logic             tag_fill_i,
  input  logic             fill_way_i,
  input  logic             lru_touch_i,
  input  logic             touch_way_i,
  output logic             hit_o,
  output logic             hit_way_o,
  output logic             lru_way_o
);

  localparam int IDX_LSB = WORD_W + 2;
  localparam int TAG_LSB = IDX_LSB + SET_W;
  localparam int TAG_W   = 32 - TAG_LSB;
  localparam int SETS    = 1 << SET_W;

  logic [SET_W-1:0] set_idx;
  logic [TAG_W-1:0] tag_in;

  // Registered lookup address, lines up with the RAM output
  logic [SET_W-1:0] set_q;
  logic [TAG_W-1:0] tag_q;

  // One bit per set, names the least recently used way
  logic [SETS-1:0] lru_q;
  logic [1:0]      way_hit;

  assign set_idx = adr_i[TAG_LSB-1:IDX_LSB];
  assign tag_in  = adr_i[31:TAG_LSB];

  always_ff @(posedge clk) begin
    set_q <= set_idx;
    tag_q <= tag_in;
  end

  for (genvar w = 0; w < 2; w++) begin : g_way
    localparam logic WAY = 1'(w);

    logic [TAG_W-1:0] ram [SETS];
    logic [TAG_W-1:0] rd_q;
    logic [SETS-1:0]  valid_q;
    logic             fill;

    assign fill = tag_fill_i & (fill_way_i == WAY);

    // Fill forwards the new tag so the next LOOKUP sees it
    always_ff @(posedge clk) begin
      if (fill) begin
        ram[set_idx] <= tag_in;
        rd_q         <= tag_in;
      end else begin
        rd_q <= ram[set_idx];
      end
    end

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        valid_q <= '0;
      end else if (fill) begin
        valid_q[set_idx] <= 1'b1;
      end
    end

    assign way_hit[w] = valid_q[set_q] & (rd_q == tag_q);
  end

  // Touching a way makes the other one the victim
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lru_q <= '0;
    end else if (lru_touch_i) begin
      lru_q[set_idx] <= ~touch_way_i;
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];
  assign lru_way_o = lru_q[set_q];

  // A line lives in one way only, fills go to missed lines
  a_one_way_hit : assert property (
    @(posedge clk) disable iff (rst)
    !(&way_hit)
  );

endmodule

// ==== verilog/dcache_data_store.sv ====
////////////////////////////////////////////////////////////
// Data cache data store
// One word RAM per way with byte-lane writes, synchronous
// read of both ways and hit way select
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dcache_data_store #(
  parameter int SET_W  = 4,
  parameter int WORD_W = 2
) (
  input  logic                 clk,
  input  dcache_pkg::adr_t     rd_adr_i,
  input  logic                 hit_way_i,
  input  dcache_pkg::way_wr_t  way_wr_i,
  output dcache_pkg::dat_t     dat_o
);

  // Word index is set plus word offset
  localparam int RAM_AW = SET_W + WORD_W;
  localparam int DEPTH  = 1 << RAM_AW;

  logic [RAM_AW-1:0] rd_idx;
  logic [RAM_AW-1:0] wr_idx;

  assign rd_idx = rd_adr_i[RAM_AW+1:2];
  assign wr_idx = way_wr_i.adr[RAM_AW+1:2];

  ////////////////////////////////////////////////////////////
  // Way RAMs
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < 2; w++) begin : g_way
    dcache_pkg::dat_t ram [DEPTH];
    dcache_pkg::dat_t rd_q;

    always_ff @(posedge clk) begin
      // Lane enables from the store or all lanes on refill
      if (way_wr_i.way[w]) begin
        for (int b = 0; b < 4; b++) begin
          if (way_wr_i.sel[b]) begin
            ram[wr_idx][b*8 +: 8] <= way_wr_i.dat[b*8 +: 8];
          end
        end
      end
      // Read first, a same-cycle write shows up one cycle later
      rd_q <= ram[rd_idx];
    end
  end

  // Hit way is valid in the cycle the RAM output arrives
  assign dat_o = hit_way_i ? g_way[1].rd_q : g_way[0].rd_q;

endmodule

// ==== verilog/dcache_mem_port.sv ====
////////////////////////////////////////////////////////////
// Data cache memory port
// Wishbone classic master for line refills, one word per
// cycle, and single-word write-through
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dcache_mem_port #(
  parameter int WORD_W = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  dcache_pkg::cpu_req_t      cpu_i,
  input  logic                      refill_start_i,
  input  logic                      wt_start_i,
  output dcache_pkg::wb_m2s_t       mem_o,
  input  dcache_pkg::wb_s2m_t       mem_i,
  output dcache_pkg::refill_word_t  refill_word_o,
  output logic                      refill_done_o,
  output logic                      wt_done_o
);

  // Cycle in flight, drives cyc and stb
  logic busy_q;
  // Word counter inside the line
  logic [WORD_W-1:0] cnt_q;

  // Held bus payload
  logic             we_q;
  dcache_pkg::adr_t adr_q;
  dcache_pkg::dat_t dat_q;
  dcache_pkg::sel_t sel_q;

  logic ack;
  logic last_word;

  assign ack       = busy_q & mem_i.ack;
  assign last_word = &cnt_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      busy_q <= refill_start_i | wt_start_i;
      cnt_q  <= '0;
    end else if (ack) begin
      // Refill keeps the cycle open until the last word
      if (!we_q && !last_word) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy_q && refill_start_i) begin
      // Line aligned, starting at word zero
      we_q  <= 1'b0;
      adr_q <= {cpu_i.adr[31:WORD_W+2], {WORD_W{1'b0}}, 2'b00};
      dat_q <= '0;
      sel_q <= 4'hf;
    end else if (!busy_q && wt_start_i) begin
      we_q  <= 1'b1;
      adr_q <= cpu_i.adr;
      dat_q <= cpu_i.dat;
      sel_q <= cpu_i.sel;
    end else if (ack && !we_q) begin
      adr_q[WORD_W+1:2] <= cnt_q + 1'b1;
    end
  end

  always_comb begin
    mem_o.cyc = busy_q;
    mem_o.stb = busy_q;
    mem_o.we  = we_q;
    mem_o.adr = adr_q;
    mem_o.dat = dat_q;
    mem_o.sel = sel_q;
  end

  // Returns towards the controller, one cycle per ack
  assign refill_word_o.valid = ack & ~we_q;
  assign refill_word_o.offs  = 3'(cnt_q);
  assign refill_word_o.dat   = mem_i.dat;
  assign refill_done_o       = ack & ~we_q & last_word;
  assign wt_done_o           = ack & we_q;

  // Wishbone hold rule while the slave stalls
  a_bus_hold : assert property (
    @(posedge clk) disable iff (rst)
    (mem_o.stb && !mem_i.ack) |=> (mem_o.stb && $stable(mem_o.adr) && $stable(mem_o.we))
  );

endmodule

// ==== verilog/dcache_ctrl.sv ====
////////////////////////////////////////////////////////////
// Data cache controller
// Runs the lookup, refill and write-through sequence,
// acknowledges the CPU, picks the victim way and steers
// writes into the data store
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dcache_ctrl #(
  parameter int SET_W  = 4,
  parameter int WORD_W = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  dcache_pkg::cpu_req_t      cpu_i,
  input  logic                      hit_i,
  input  logic                      hit_way_i,
  input  logic                      lru_way_i,
  input  dcache_pkg::refill_word_t  refill_word_i,
  input  logic                      refill_done_i,
  input  logic                      wt_done_i,
  output logic                      cpu_ack_o,
  output logic                      refill_start_o,
  output logic                      wt_start_o,
  output logic                      tag_fill_o,
  output logic                      fill_way_o,
  output logic                      lru_touch_o,
  output logic                      touch_way_o,
  output dcache_pkg::way_wr_t       way_wr_o
);

  // Set index position inside the byte address
  localparam int IDX_LSB = WORD_W + 2;
  localparam int IDX_MSB = IDX_LSB + SET_W - 1;

  dcache_pkg::cache_state_e state_q;
  dcache_pkg::cache_state_e state_d;

  // Way chosen for replacement, held through REFILL and TAG_FILL
  logic victim_q;

  logic req;
  logic in_lookup;
  logic rd_hit;
  logic rd_miss;
  logic wr_hit;

  assign req       = cpu_i.cyc & cpu_i.stb;
  assign in_lookup = (state_q == dcache_pkg::LOOKUP);
  assign rd_hit    = in_lookup & ~cpu_i.we & hit_i;
  assign rd_miss   = in_lookup & ~cpu_i.we & ~hit_i;
  assign wr_hit    = in_lookup & cpu_i.we & hit_i;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_pkg::IDLE: begin
        if (req) begin
          state_d = dcache_pkg::LOOKUP;
        end
      end
      // Tag and data RAM outputs are valid here
      dcache_pkg::LOOKUP: begin
        if (cpu_i.we) begin
          state_d = dcache_pkg::WRITE_THRU;
        end else if (hit_i) begin
          state_d = dcache_pkg::IDLE;
        end else begin
          state_d = dcache_pkg::REFILL;
        end
      end
      dcache_pkg::REFILL: begin
        if (refill_done_i) begin
          state_d = dcache_pkg::TAG_FILL;
        end
      end
      // Back to LOOKUP, which then hits on the new line
      dcache_pkg::TAG_FILL: begin
        state_d = dcache_pkg::LOOKUP;
      end
      dcache_pkg::WRITE_THRU: begin
        if (wt_done_i) begin
          state_d = dcache_pkg::IDLE;
        end
      end
      default: begin
        state_d = dcache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q  <= dcache_pkg::IDLE;
      victim_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sample the LRU way as the refill is launched
      if (rd_miss) begin
        victim_q <= lru_way_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Reads ack on a hit, writes once memory took the word
  assign cpu_ack_o = rd_hit | ((state_q == dcache_pkg::WRITE_THRU) & wt_done_i);

  assign refill_start_o = rd_miss;
  assign wt_start_o     = in_lookup & cpu_i.we;

  assign tag_fill_o = (state_q == dcache_pkg::TAG_FILL);
  assign fill_way_o = victim_q;

  // A hit touches its way, a fill touches the refilled way
  assign lru_touch_o = (in_lookup & hit_i) | tag_fill_o;
  assign touch_way_o = tag_fill_o ? victim_q : hit_way_i;

  always_comb begin
    way_wr_o = '0;
    if (wr_hit) begin
      // Store hit, byte lanes straight from the CPU
      way_wr_o.way = {hit_way_i, ~hit_way_i};
      way_wr_o.adr = cpu_i.adr;
      way_wr_o.dat = cpu_i.dat;
      way_wr_o.sel = cpu_i.sel;
    end else if ((state_q == dcache_pkg::REFILL) && refill_word_i.valid) begin
      // Refill word into the victim, full word
      way_wr_o.way = {victim_q, ~victim_q};
      way_wr_o.adr = {cpu_i.adr[31:IDX_LSB], refill_word_i.offs[WORD_W-1:0], 2'b00};
      way_wr_o.dat = refill_word_i.dat;
      way_wr_o.sel = 4'hf;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Every ack hands the FSM back to IDLE, which gives no ack
  a_no_ack_idle : assert property (
    @(posedge clk) disable iff (rst)
    cpu_ack_o |=> (state_q == dcache_pkg::IDLE) && !cpu_ack_o
  );

  // Tag fill and refill words target the set looked up first
  a_set_held : assert property (
    @(posedge clk) disable iff (rst)
    (state_q != dcache_pkg::IDLE) |-> $stable(cpu_i.adr[IDX_MSB:IDX_LSB])
  );

endmodule

// ==== verilog/dcache_top.sv ====
////////////////////////////////////////////////////////////
// Two-way set-associative data cache, top level
// Wishbone classic slave towards the CPU, Wishbone classic
// master towards memory, write-through without allocate
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module dcache_top #(
  parameter int SET_W  = 4,
  parameter int WORD_W = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  dcache_pkg::cpu_req_t   cpu_i,
  output logic                   cpu_ack_o,
  output dcache_pkg::dat_t       cpu_dat_o,
  output dcache_pkg::wb_m2s_t    mem_o,
  input  dcache_pkg::wb_s2m_t    mem_i
);

  // Tag store results
  logic hit;
  logic hit_way;
  logic lru_way;

  // Controller requests
  logic tag_fill;
  logic fill_way;
  logic lru_touch;
  logic touch_way;
  logic refill_start;
  logic wt_start;
  dcache_pkg::way_wr_t way_wr;

  // Memory port returns
  dcache_pkg::refill_word_t refill_word;
  logic refill_done;
  logic wt_done;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  dcache_ctrl #(
    .SET_W  (SET_W),
    .WORD_W (WORD_W)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .cpu_i          (cpu_i),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .lru_way_i      (lru_way),
    .refill_word_i  (refill_word),
    .refill_done_i  (refill_done),
    .wt_done_i      (wt_done),
    .cpu_ack_o      (cpu_ack_o),
    .refill_start_o (refill_start),
    .wt_start_o     (wt_start),
    .tag_fill_o     (tag_fill),
    .fill_way_o     (fill_way),
    .lru_touch_o    (lru_touch),
    .touch_way_o    (touch_way),
    .way_wr_o       (way_wr)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Both stores look up the address the CPU holds on the bus
  dcache_tag_store #(
    .SET_W  (SET_W),
    .WORD_W (WORD_W)
  ) u_tag_store (
    .clk         (clk),
    .rst         (rst),
    .adr_i       (cpu_i.adr),
    .tag_fill_i  (tag_fill),
    .fill_way_i  (fill_way),
    .lru_touch_i (lru_touch),
    .touch_way_i (touch_way),
    .hit_o       (hit),
    .hit_way_o   (hit_way),
    .lru_way_o   (lru_way)
  );

  dcache_data_store #(
    .SET_W  (SET_W),
    .WORD_W (WORD_W)
  ) u_data_store (
    .clk       (clk),
    .rd_adr_i  (cpu_i.adr),
    .hit_way_i (hit_way),
    .way_wr_i  (way_wr),
    .dat_o     (cpu_dat_o)
  );

  dcache_mem_port #(
    .WORD_W (WORD_W)
  ) u_mem_port (
    .clk            (clk),
    .rst            (rst),
    .cpu_i          (cpu_i),
    .refill_start_i (refill_start),
    .wt_start_i     (wt_start),
    .mem_o          (mem_o),
    .mem_i          (mem_i),
    .refill_word_o  (refill_word),
    .refill_done_o  (refill_done),
    .wt_done_o      (wt_done)
  );

endmodule

// ==== dv/wb_mem_model.sv ====
////////////////////////////////////////////////////////////
// Wishbone classic slave memory for the data cache testbench
// Random acknowledge delay, byte-lane writes, and a check of
// every memory write against the logged CPU writes
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module wb_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  dcache_pkg::wb_m2s_t  m2s_i,
  output dcache_pkg::wb_s2m_t  s2m_o,
  output logic                 wr_err_o
);

  // Sparse word storage, unwritten words come from the fill pattern
  dcache_pkg::dat_t store [logic [29:0]];

  // CPU writes still expected on the memory side, oldest first
  dcache_pkg::wb_m2s_t wr_log [$];

  // Wait cycles left before the next ack
  logic [1:0] wait_q;

  function automatic dcache_pkg::dat_t read_word(input dcache_pkg::adr_t adr);
    if (store.exists(adr[31:2])) begin
      return store[adr[31:2]];
    end
    // Fill pattern, word byte address xor a fixed mask
    return {adr[31:2], 2'b00} ^ 32'h5a5a0000;
  endfunction

  // Called from the testbench as each CPU write is issued
  function automatic void expect_write(input dcache_pkg::adr_t adr,
                                       input dcache_pkg::dat_t dat,
                                       input dcache_pkg::sel_t sel);
    dcache_pkg::wb_m2s_t w;
    w     = '0;
    w.cyc = 1'b1;
    w.stb = 1'b1;
    w.we  = 1'b1;
    w.adr = adr;
    w.dat = dat;
    w.sel = sel;
    wr_log.push_back(w);
  endfunction

  function automatic int pending_writes();
    return wr_log.size();
  endfunction

  function automatic logic write_logged(input dcache_pkg::wb_m2s_t got);
    dcache_pkg::wb_m2s_t exp;
    logic ok;
    if (wr_log.size() == 0) begin
      $display("Memory write to %h arrived with no CPU write logged", got.adr);
      return 1'b0;
    end
    exp = wr_log.pop_front();
    ok  = 1'b1;
    if (got.adr !== exp.adr) begin
      $display("Mismatch mem_o.adr: got %h expected %h", got.adr, exp.adr);
      ok = 1'b0;
    end
    if (got.dat !== exp.dat) begin
      $display("Mismatch mem_o.dat: got %h expected %h", got.dat, exp.dat);
      ok = 1'b0;
    end
    if (got.sel !== exp.sel) begin
      $display("Mismatch mem_o.sel: got %h expected %h", got.sel, exp.sel);
      ok = 1'b0;
    end
    return ok;
  endfunction

  ////////////////////////////////////////////////////////////
  // Slave cycle, one registered ack per request
  ////////////////////////////////////////////////////////////

  always @(posedge clk or posedge rst) begin
    dcache_pkg::dat_t word;
    if (rst) begin
      s2m_o    <= '0;
      wait_q   <= '0;
      wr_err_o <= 1'b0;
    end else if (s2m_o.ack) begin
      // Ack lasts one cycle, the master may present a new word next
      s2m_o.ack <= 1'b0;
    end else if (m2s_i.cyc && m2s_i.stb) begin
      if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else begin
        word = read_word(m2s_i.adr);
        if (m2s_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (m2s_i.sel[b]) begin
              word[b*8 +: 8] = m2s_i.dat[b*8 +: 8];
            end
          end
          store[m2s_i.adr[31:2]] = word;
          if (!write_logged(m2s_i)) begin
            wr_err_o <= 1'b1;
          end
        end
        s2m_o.ack <= 1'b1;
        s2m_o.dat <= word;
        wait_q    <= 2'($urandom_range(3, 0));
      end
    end
  end

endmodule

// ==== dv/tb_dcache.sv ====
////////////////////////////////////////////////////////////
// Data cache testbench
// Replays CPU reads and writes from a stimulus file, checks
// read data, refill traffic and single acks per request
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_dcache;

  localparam int SET_W      = 4;
  // Eight words per line, the stimulus addresses assume 32 byte lines
  localparam int WORD_W     = 3;
  localparam int LINE_WORDS = 1 << WORD_W;
  localparam int STIM_MAX   = 32;
  localparam int STIM_COLS  = 6;
  localparam int OP_TIME_NS = 200;

  logic                     clk;
  logic                     rst;
  dcache_pkg::cpu_req_t     cpu;
  logic                     cpu_ack;
  dcache_pkg::dat_t         cpu_dat;
  dcache_pkg::wb_m2s_t      mem_m2s;
  dcache_pkg::wb_s2m_t      mem_s2m;
  logic                     mem_err;

  // Columns per line: kind, adr, wdat, sel, expected data, refill
  logic [31:0] stim [STIM_MAX*STIM_COLS];
  int n_ops;

  // Per operation counters, cleared as each request starts
  int rd_cnt;
  int ack_cnt;

  dcache_top #(
    .SET_W  (SET_W),
    .WORD_W (WORD_W)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .cpu_i     (cpu),
    .cpu_ack_o (cpu_ack),
    .cpu_dat_o (cpu_dat),
    .mem_o     (mem_m2s),
    .mem_i     (mem_s2m)
  );

  wb_mem_model u_mem (
    .clk      (clk),
    .rst      (rst),
    .m2s_i    (mem_m2s),
    .s2m_o    (mem_s2m),
    .wr_err_o (mem_err)
  );

  always #2 clk = ~clk;

  // Count CPU acks and acked memory reads
  always @(posedge clk) begin
    if (cpu_ack) begin
      ack_cnt = ack_cnt + 1;
    end
    if (mem_m2s.cyc && mem_m2s.stb && !mem_m2s.we && mem_s2m.ack) begin
      rd_cnt = rd_cnt + 1;
    end
  end

  always @(posedge clk) begin
    if (mem_err) begin
      $display("Memory model saw a write-through that differs from the CPU write");
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_dat(input string name, input dcache_pkg::dat_t got,
                           input dcache_pkg::dat_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // A refill reads one full line, anything else reads nothing
  task automatic check_refill(input bit exp_refill, input int rd_cycles);
    int exp_cycles;
    exp_cycles = exp_refill ? LINE_WORDS : 0;
    if (rd_cycles != exp_cycles) begin
      $display("Mismatch mem read cycles: got %h expected %h", rd_cycles, exp_cycles);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus replay
  ////////////////////////////////////////////////////////////

  task automatic run_op(input int i);
    logic [31:0]      kind;
    logic [31:0]      adr;
    logic [31:0]      wdat;
    logic [31:0]      sel;
    logic [31:0]      exp_dat;
    logic [31:0]      exp_refill;
    dcache_pkg::dat_t rd_dat;
    kind       = stim[i*STIM_COLS];
    adr        = stim[i*STIM_COLS+1];
    wdat       = stim[i*STIM_COLS+2];
    sel        = stim[i*STIM_COLS+3];
    exp_dat    = stim[i*STIM_COLS+4];
    exp_refill = stim[i*STIM_COLS+5];
    if (kind[0]) begin
      u_mem.expect_write(adr, wdat, sel[3:0]);
    end
    rd_cnt  = 0;
    ack_cnt = 0;
    cpu.cyc = 1'b1;
    cpu.stb = 1'b1;
    cpu.we  = kind[0];
    cpu.adr = adr;
    cpu.dat = wdat;
    cpu.sel = sel[3:0];
    // Fields stay put until the ack, the watchdog bounds the wait
    @(negedge clk);
    while (!cpu_ack) begin
      @(negedge clk);
    end
    rd_dat  = cpu_dat;
    // Address stays on the bus so the set index holds through the last state
    cpu.cyc = 1'b0;
    cpu.stb = 1'b0;
    // Two more edges so a stretched or repeated ack is still counted
    repeat (2) @(negedge clk);
    if (ack_cnt != 1) begin
      $display("CPU request %0d was acknowledged %0d times instead of once", i, ack_cnt);
      abort_run();
    end
    check_refill(exp_refill[0], rd_cnt);
    if (!kind[0]) begin
      check_dat("cpu_dat_o", rd_dat, exp_dat);
    end
  endtask

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    cpu     = '0;
    n_ops   = 0;
    rd_cnt  = 0;
    ack_cnt = 0;
    void'($urandom(32'hb03d896b));
    // Unused lines read as all ones and mark the end
    for (int i = 0; i < STIM_MAX*STIM_COLS; i++) begin
      stim[i] = '1;
    end
    $readmemh("dv/dcache_stim.mem", stim);
    while (n_ops < STIM_MAX && stim[n_ops*STIM_COLS] != '1) begin
      n_ops = n_ops + 1;
    end
    if (n_ops == 0) begin
      $display("No operations were found in the stimulus file");
      abort_run();
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    if (u_mem.pending_writes() != 0) begin
      $display("Some CPU writes never reached the memory port");
      abort_run();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // Watchdog, budget scales with the number of operations
  initial begin
    @(negedge rst);
    #(n_ops * OP_TIME_NS);
    $display("Timeout, the operations did not finish in time");
    abort_run();
  end

endmodule

// ==== tb.f ====
verilog/dcache_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_mem_port.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/wb_mem_model.sv
dv/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Build the data cache testbench with Verilator, run it, then search the log
verilator --binary --timing --assert -f tb.f --top-module tb_dcache \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_dcache > sim.log 2>&1
cat sim.log

grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== dv/dcache_stim.mem ====
// kind adr wdat sel exp_dat refill
// kind 0 read, 1 write; refill 1 when a line fill is expected
00000000 00000110 00000000 0000000f 5a5a0110 00000001
00000000 00000110 00000000 0000000f 5a5a0110 00000000
00000000 0000011c 00000000 0000000f 5a5a011c 00000000
00000001 00000114 a1b2c3d4 00000003 00000000 00000000
00000000 00000114 00000000 0000000f 5a5ac3d4 00000000
00000001 00000228 11223344 0000000c 00000000 00000000
00000000 00000228 00000000 0000000f 11220228 00000001
00000000 00000030 00000000 0000000f 5a5a0030 00000001
00000000 00001030 00000000 0000000f 5a5a1030 00000001
00000000 00000030 00000000 0000000f 5a5a0030 00000000
00000000 00002030 00000000 0000000f 5a5a2030 00000001
00000000 00000030 00000000 0000000f 5a5a0030 00000000
00000000 00001030 00000000 0000000f 5a5a1030 00000001
00000001 00000034 deadbeef 0000000f 00000000 00000000
00000000 00000034 00000000 0000000f deadbeef 00000000
00000001 0000011c 99887766 00000004 00000000 00000000
00000000 0000011c 00000000 0000000f 5a88011c 00000000
00000000 00000100 00000000 0000000f 5a5a0100 00000000
